//--- rtl/rv_settings.svh
// rv32i core settings
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

`define XLEN      32            // data and address width
`define REG_COUNT 32            // integer registers, x0 included
`define RESET_PC  32'h8000_0000 // first fetch address
`define INST_STEP 4             // sequential pc increment

`endif

//--- rtl/rv_pkg.sv
// rv32i core types
`include "rv_settings.svh"

package rv_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [4:0]       reg_idx_t;

    typedef enum logic [6:0] {
        opc_op     = 7'b0110011, // register-register alu
        opc_op_imm = 7'b0010011, // register-immediate alu
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011
    } opcode_t;

    typedef enum logic [2:0] {
        type_r,
        type_i,
        type_u,
        type_j,
        type_b,
        type_n  // not supported, runs as a nop
    } inst_type_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

    typedef enum logic [1:0] {
        st_request, // req high, waiting for ack
        st_release, // req low, waiting for ack to drop
        st_execute  // one cycle, instruction commits
    } fetch_state_t;

    typedef struct packed {
        opcode_t    opcode;
        logic [2:0] funct3;
        logic       funct7_b5;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        word_t      imm;
        inst_type_t inst_type;
        logic       wb_en;
    } decoded_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t rd;
        logic     wb_en;
        word_t    result;
    } retire_t;

    typedef struct packed {
        logic  req;
        word_t addr;
    } imem_req_t;

endpackage

//--- rtl/fetch_seq.sv
// instruction fetch sequencer
`timescale 1ns/1ns

module fetch_seq import rv_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  word_t     pc,
    input  logic      imem_ack,
    input  word_t     imem_data,
    output imem_req_t imem_req,
    output word_t     inst,
    output logic      commit
);

    fetch_state_t state;
    logic         req_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_request;
            req_q <= 1'b0; // raised on the first cycle out of reset
        end else begin
            case (state)
                st_request: begin
                    if (req_q && imem_ack) begin
                        inst  <= imem_data; // capture on ack
                        req_q <= 1'b0;
                        state <= st_release;
                    end else begin
                        req_q <= 1'b1;
                    end
                end
                st_release: begin
                    if (!imem_ack) state <= st_execute; // memory finished its phase
                end
                default: begin
                    req_q <= 1'b1; // next fetch starts right away
                    state <= st_request;
                end
            endcase
        end
    end

    assign imem_req = '{req: req_q, addr: pc}; // pc only moves at commit
    assign commit   = (state == st_execute);

    // four-phase rule, req may not drop before ack
    req_held_until_ack: assert property (
        @(posedge clk) disable iff (reset) imem_req.req && !imem_ack |=> imem_req.req
    );

endmodule

//--- rtl/pc_counter.sv
// program counter and retired count
`timescale 1ns/1ns
`include "rv_settings.svh"

module pc_counter import rv_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  commit,
    input  logic  jump_en,
    input  word_t jump_target,
    output word_t pc,
    output word_t instret
);

    word_t next_pc;

    always_comb begin
        if (jump_en) begin
            next_pc = jump_target;
        end else begin
            next_pc = pc + word_t'(`INST_STEP); // sequential
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc      <= `RESET_PC;
            instret <= '0;
        end else if (commit) begin
            pc      <= next_pc;
            instret <= instret + 1'b1;
        end
    end

endmodule

//--- rtl/inst_decoder.sv
// rv32i instruction decoder
`timescale 1ns/1ns

module inst_decoder import rv_pkg::*; (
    input  word_t    inst,
    output decoded_t dec
);

    opcode_t    opcode;
    inst_type_t inst_type;
    word_t      imm;

    assign opcode = opcode_t'(inst[6:0]);

    always_comb begin
        case (opcode)
            opc_op:              inst_type = type_r;
            opc_op_imm, opc_jalr: inst_type = type_i;
            opc_lui, opc_auipc:  inst_type = type_u;
            opc_jal:             inst_type = type_j;
            opc_branch:          inst_type = type_b;
            default:             inst_type = type_n; // dropped or unknown opcode
        endcase
    end

    always_comb begin
        case (inst_type)
            type_i:  imm = {{20{inst[31]}}, inst[31:20]};
            type_u:  imm = {inst[31:12], 12'b0};
            type_j:  imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            type_b:  imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            default: imm = '0; // r type and nops carry no immediate
        endcase
    end

    always_comb begin
        dec.opcode    = opcode;
        dec.funct3    = inst[14:12];
        dec.funct7_b5 = inst[30];
        dec.rd        = inst[11:7];
        dec.rs1       = inst[19:15];
        dec.rs2       = inst[24:20];
        dec.imm       = imm;
        dec.inst_type = inst_type;
        // branches and nops never write, x0 stays zero
        dec.wb_en     = (inst_type inside {type_r, type_i, type_u, type_j}) &&
                        (inst[11:7] != '0);
    end

endmodule

//--- rtl/alu.sv
// 32-bit integer alu
`timescale 1ns/1ns
`include "rv_settings.svh"

module alu import rv_pkg::*; (
    input  word_t   a,
    input  word_t   b,
    input  alu_op_t op,
    output word_t   result
);

    localparam int SHAMT_W = $clog2(`XLEN);

    logic               is_sub;
    word_t              b_eff;
    word_t              sum;
    logic               carry;
    logic               overflow;
    logic [SHAMT_W-1:0] shamt;

    assign is_sub = (op == alu_sub) || (op == alu_slt) || (op == alu_sltu);
    assign b_eff  = b ^ {`XLEN{is_sub}}; // two's complement with carry in
    assign {carry, sum} = {1'b0, a} + {1'b0, b_eff} + {{`XLEN{1'b0}}, is_sub};

    // operands of equal sign giving a result of the other sign
    assign overflow = (a[`XLEN-1] == b_eff[`XLEN-1]) && (sum[`XLEN-1] != a[`XLEN-1]);
    assign shamt    = b[SHAMT_W-1:0];

    always_comb begin
        case (op)
            alu_add, alu_sub: result = sum;
            alu_sll:  result = a << shamt;
            alu_slt:  result = {{(`XLEN-1){1'b0}}, sum[`XLEN-1] ^ overflow};
            alu_sltu: result = {{(`XLEN-1){1'b0}}, ~carry}; // borrow out
            alu_xor:  result = a ^ b;
            alu_srl:  result = a >> shamt;
            alu_sra:  result = word_t'($signed(a) >>> shamt);
            alu_or:   result = a | b;
            alu_and:  result = a & b;
            default:  result = '0;
        endcase
    end

endmodule

//--- rtl/exec_unit.sv
// execute unit
`timescale 1ns/1ns
`include "rv_settings.svh"

module exec_unit import rv_pkg::*; (
    input  decoded_t dec,
    input  word_t    pc,
    input  word_t    rdata1,
    input  word_t    rdata2,
    input  logic     commit,
    output logic     jump_en,
    output word_t    jump_target,
    output word_t    wb_data,
    output retire_t  retire
);

    word_t   alu_a;
    word_t   alu_b;
    word_t   alu_result;
    word_t   link;
    alu_op_t alu_op;
    logic    taken;

    alu alu_i (
        .a      (alu_a),
        .b      (alu_b),
        .op     (alu_op),
        .result (alu_result)
    );

    assign link = pc + word_t'(`INST_STEP); // return address for jal and jalr

    always_comb begin
        alu_a = rdata1;
        alu_b = rdata2;
        case (dec.inst_type)
            type_i: alu_b = dec.imm; // op_imm and jalr
            type_u: begin
                alu_a = (dec.opcode == opc_lui) ? '0 : pc;
                alu_b = dec.imm;
            end
            type_j, type_b: begin
                alu_a = pc; // pc relative
                alu_b = dec.imm;
            end
            default: ;
        endcase
    end

    always_comb begin
        alu_op = alu_add;
        if (dec.opcode == opc_op || dec.opcode == opc_op_imm) begin
            case (dec.funct3)
                3'b000:  alu_op = (dec.opcode == opc_op && dec.funct7_b5) ? alu_sub : alu_add;
                3'b001:  alu_op = alu_sll;
                3'b010:  alu_op = alu_slt;
                3'b011:  alu_op = alu_sltu;
                3'b100:  alu_op = alu_xor;
                3'b101:  alu_op = dec.funct7_b5 ? alu_sra : alu_srl;
                3'b110:  alu_op = alu_or;
                default: alu_op = alu_and;
            endcase
        end
    end

    always_comb begin
        case (dec.funct3)
            3'b000:  taken = (rdata1 == rdata2);                   // beq
            3'b001:  taken = (rdata1 != rdata2);                   // bne
            3'b100:  taken = ($signed(rdata1) < $signed(rdata2));  // blt
            3'b101:  taken = ($signed(rdata1) >= $signed(rdata2)); // bge
            3'b110:  taken = (rdata1 < rdata2);                    // bltu
            3'b111:  taken = (rdata1 >= rdata2);                   // bgeu
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        jump_en     = 1'b0;
        jump_target = alu_result;
        case (dec.opcode)
            opc_jal:    jump_en = 1'b1;
            opc_jalr: begin
                jump_en     = 1'b1;
                jump_target = {alu_result[`XLEN-1:1], 1'b0}; // bit 0 cleared
            end
            opc_branch: jump_en = taken;
            default: ;
        endcase
    end

    always_comb begin
        case (dec.opcode)
            opc_op, opc_op_imm, opc_lui, opc_auipc: wb_data = alu_result;
            opc_jal, opc_jalr:                      wb_data = link;
            default:                                wb_data = '0;
        endcase
    end

    assign retire = '{valid: commit, pc: pc, rd: dec.rd, wb_en: dec.wb_en, result: wb_data};

endmodule

//--- rtl/reg_file.sv
// integer register file
`timescale 1ns/1ns
`include "rv_settings.svh"

module reg_file import rv_pkg::*; (
    input  logic     clk,
    input  logic     commit,
    input  decoded_t dec,
    input  word_t    wb_data,
    output word_t    rdata1,
    output word_t    rdata2
);

    word_t regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (commit && dec.wb_en) begin
            regs[dec.rd] <= wb_data;
        end
    end

    assign rdata1 = (dec.rs1 == '0) ? '0 : regs[dec.rs1]; // x0 hardwired
    assign rdata2 = (dec.rs2 == '0) ? '0 : regs[dec.rs2];

    // decoder must keep writes away from x0
    no_x0_write: assert property (
        @(posedge clk) commit && dec.wb_en |-> dec.rd != '0
    );

endmodule

//--- rtl/rv_core.sv
// rv32i core top level
`timescale 1ns/1ns

module rv_core import rv_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    output imem_req_t imem_req,
    input  logic      imem_ack,
    input  word_t     imem_data,
    output retire_t   retire,
    output word_t     instret
);

    word_t    inst;
    logic     commit;
    decoded_t dec;
    word_t    rdata1;
    word_t    rdata2;
    logic     jump_en;
    word_t    jump_target;
    word_t    wb_data;
    word_t    pc;

    fetch_seq fetch_seq_i (
        .clk       (clk),
        .reset     (reset),
        .pc        (pc),
        .imem_ack  (imem_ack),
        .imem_data (imem_data),
        .imem_req  (imem_req),
        .inst      (inst),
        .commit    (commit)
    );

    pc_counter pc_counter_i (
        .clk         (clk),
        .reset       (reset),
        .commit      (commit),
        .jump_en     (jump_en),
        .jump_target (jump_target),
        .pc          (pc),
        .instret     (instret)
    );

    inst_decoder inst_decoder_i (
        .inst (inst),
        .dec  (dec)
    );

    exec_unit exec_unit_i (
        .dec         (dec),
        .pc          (pc),
        .rdata1      (rdata1),
        .rdata2      (rdata2),
        .commit      (commit),
        .jump_en     (jump_en),
        .jump_target (jump_target),
        .wb_data     (wb_data),
        .retire      (retire)
    );

    reg_file reg_file_i (
        .clk     (clk),
        .commit  (commit),
        .dec     (dec),
        .wb_data (wb_data),
        .rdata1  (rdata1),
        .rdata2  (rdata2)
    );

endmodule

//--- bench/tb_clock.sv
// testbench clock source
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD = 4 // ns
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

endmodule

//--- bench/rv_core_tb.sv
// rv32i core testbench
`timescale 1ns/1ns
`include "rv_settings.svh"

module rv_core_tb import rv_pkg::*; ();

    localparam int NUM_INST       = 400;
    localparam int TIMEOUT_CYCLES = NUM_INST * 12 + 20;

    logic      clk;
    logic      reset;
    logic      imem_ack;
    word_t     imem_data;
    imem_req_t imem_req;
    retire_t   retire;
    word_t     instret;

    integer seed = 32'h2cb4f5aa;
    int     cycles;
    int     retired;
    int     mismatches;
    int     failures;
    int     resp_phase; // 0 idle, 1 ack delay, 2 ack high, 3 release delay
    int     resp_delay;
    logic   reset_q;
    word_t  cur_inst;
    word_t  model_pc;
    word_t  model_regs [`REG_COUNT];
    logic   written [`REG_COUNT]; // register holds a known value

    tb_clock clock_i (.clk(clk));

    rv_core dut_i (
        .clk       (clk),
        .reset     (reset),
        .imem_req  (imem_req),
        .imem_ack  (imem_ack),
        .imem_data (imem_data),
        .retire    (retire),
        .instret   (instret)
    );

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            mismatches++;
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_retire(input string name, input retire_t expected,
                                input retire_t actual);
        if (actual !== expected) begin
            mismatches++;
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    function automatic int unsigned pick(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // only read registers the model already knows
    function automatic logic [4:0] src_reg(input logic [4:0] idx);
        return written[idx] ? idx : 5'd0;
    endfunction

    function automatic word_t random_inst();
        logic [31:0] r;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  bad_opc;
        word_t       inst;
        r   = $random(seed);
        rs1 = src_reg(r[19:15]);
        rs2 = src_reg(r[24:20]);
        f3  = r[14:12];
        case (pick(10))
            0, 1: inst = {1'b0, r[30] & (f3 == 3'b000 || f3 == 3'b101), 5'b0,
                          rs2, rs1, f3, r[11:7], 7'b0110011};
            2, 3: begin
                if (f3 == 3'b001) begin
                    inst = {7'b0, r[24:20], rs1, f3, r[11:7], 7'b0010011};
                end else if (f3 == 3'b101) begin
                    inst = {1'b0, r[30], 5'b0, r[24:20], rs1, f3, r[11:7], 7'b0010011};
                end else begin
                    inst = {r[31:20], rs1, f3, r[11:7], 7'b0010011};
                end
            end
            4: inst = {r[31:12], r[11:7], 7'b0110111}; // lui
            5: inst = {r[31:12], r[11:7], 7'b0010111}; // auipc
            6: inst = {r[31:12], r[11:7], 7'b1101111}; // jal
            7: inst = {r[31:20], rs1, 3'b000, r[11:7], 7'b1100111};
            8: begin
                if (f3[2:1] == 2'b01) f3[2] = 1'b1; // no branch on 010 and 011
                inst = {r[31:25], rs2, rs1, f3, r[11:7], 7'b1100011};
            end
            default: begin
                case (pick(4))
                    0:       bad_opc = 7'b0000011; // load
                    1:       bad_opc = 7'b0100011; // store
                    2:       bad_opc = 7'b1110011; // system
                    default: bad_opc = 7'b0001111; // fence
                endcase
                inst = {r[31:7], bad_opc};
            end
        endcase
        return inst;
    endfunction

    // reference execution of one instruction
    task automatic model_step(input word_t inst, output retire_t exp, output word_t next_pc);
        word_t a;
        word_t b;
        word_t imm_i;
        word_t res;
        logic  writes;
        logic  taken;
        logic  alt;
        a      = model_regs[inst[19:15]];
        b      = model_regs[inst[24:20]];
        imm_i  = {{20{inst[31]}}, inst[31:20]};
        res    = '0;
        writes = 1'b0;
        taken  = 1'b0;
        next_pc = model_pc + 32'd4;
        case (inst[6:0])
            7'b0110011, 7'b0010011: begin
                alt = inst[30] & (inst[14:12] == 3'b101 || inst[6:0] == 7'b0110011);
                if (inst[6:0] == 7'b0010011) b = imm_i;
                writes = 1'b1;
                case (inst[14:12])
                    3'b000:  res = alt ? a - b : a + b;
                    3'b001:  res = a << b[4:0];
                    3'b010:  res = {31'b0, $signed(a) < $signed(b)};
                    3'b011:  res = {31'b0, a < b};
                    3'b100:  res = a ^ b;
                    3'b101:  res = alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
                    3'b110:  res = a | b;
                    default: res = a & b;
                endcase
            end
            7'b0110111: begin
                writes = 1'b1;
                res    = {inst[31:12], 12'b0};
            end
            7'b0010111: begin
                writes = 1'b1;
                res    = model_pc + {inst[31:12], 12'b0};
            end
            7'b1101111: begin
                writes  = 1'b1;
                res     = model_pc + 32'd4; // link
                next_pc = model_pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            7'b1100111: begin
                writes  = 1'b1;
                res     = model_pc + 32'd4;
                next_pc = (a + imm_i) & ~32'd1;
            end
            7'b1100011: begin
                case (inst[14:12])
                    3'b000:  taken = (a == b);
                    3'b001:  taken = (a != b);
                    3'b100:  taken = ($signed(a) < $signed(b));
                    3'b101:  taken = ($signed(a) >= $signed(b));
                    3'b110:  taken = (a < b);
                    default: taken = (a >= b);
                endcase
                if (taken) begin
                    next_pc = model_pc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
                end
            end
            default: ; // unsupported opcode acts as a nop
        endcase
        exp.valid  = 1'b1;
        exp.pc     = model_pc;
        exp.rd     = inst[11:7];
        exp.wb_en  = writes && (inst[11:7] != 5'd0);
        exp.result = res;
    endtask

    always @(posedge clk) begin
        retire_t exp_ret;
        word_t   next_pc;
        cycles = cycles + 1;
        if (reset_q && (imem_req.req || retire.valid)) begin
            failures++;
            $display("fetch request or retire valid was high during reset");
        end
        if (reset) begin
            imem_ack   <= 1'b0;
            imem_data  <= '0;
            resp_phase = 0;
            model_pc   = `RESET_PC;
            retired    = 0;
            for (int i = 0; i < `REG_COUNT; i++) begin
                model_regs[i] = '0;
                written[i]    = (i == 0);
            end
        end else begin
            // memory side of the fetch handshake
            if (resp_phase == 0 && imem_req.req) begin
                check_word($sformatf("fetch addr %0d", retired), model_pc, imem_req.addr);
                cur_inst   = random_inst();
                resp_delay = pick(4);
                resp_phase = 1;
            end
            if (resp_phase == 1) begin
                if (resp_delay == 0) begin
                    imem_ack   <= 1'b1;
                    imem_data  <= cur_inst;
                    resp_phase = 2;
                end else begin
                    resp_delay--;
                end
            end else if (resp_phase == 2 && !imem_req.req) begin
                resp_delay = pick(4);
                resp_phase = 3;
            end
            if (resp_phase == 3) begin
                if (resp_delay == 0) begin
                    imem_ack   <= 1'b0;
                    resp_phase = 0;
                end else begin
                    resp_delay--;
                end
            end

            check_word("instret", word_t'(retired), instret);
            if (retire.valid) begin
                model_step(cur_inst, exp_ret, next_pc);
                check_retire($sformatf("retire %0d", retired), exp_ret, retire);
                if (exp_ret.wb_en) begin
                    model_regs[exp_ret.rd] = exp_ret.result;
                    written[exp_ret.rd]    = 1'b1;
                end
                model_pc = next_pc;
                retired  = retired + 1;
            end
        end
        reset_q = reset;
    end

    initial begin
        reset      <= 1'b1;
        imem_ack   <= 1'b0;
        imem_data  <= '0;
        reset_q    = 1'b0;
        cycles     = 0;
        retired    = 0;
        mismatches = 0;
        failures   = 0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        while (retired < NUM_INST && cycles < TIMEOUT_CYCLES) @(negedge clk);
        if (retired < NUM_INST) begin
            failures++;
            $display("timeout: only %0d of %0d instructions retired in %0d cycles",
                     retired, NUM_INST, cycles);
        end
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+rtl
rtl/rv_pkg.sv
rtl/fetch_seq.sv
rtl/pc_counter.sv
rtl/inst_decoder.sv
rtl/alu.sv
rtl/exec_unit.sv
rtl/reg_file.sv
rtl/rv_core.sv
bench/tb_clock.sv
bench/rv_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module rv_core_tb \
    -o rv_core_sim &&
./obj_dir/rv_core_sim | tee /dev/stderr | grep -qF "Simulation finished: PASS" &&
echo "run_sim: passed" ||
{ echo "run_sim: failed"; exit 1; }
